// File: rtl/sram_ctrl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Widths are fixed here for a 32-bit Wishbone bus over a 16-bit SRAM
// Only linear incrementing bursts are supported and BTE is not carried
////////////////////////////////////////////////////////////////////////////
package sram_ctrl_pkg;

    // Wishbone side
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = 4;
    localparam int WB_ADDR_W = 32;

    // SRAM side, 1M words of 16 bits
    localparam int SRAM_DATA_W = 16;
    localparam int SRAM_ADDR_W = 20;
    localparam int SRAM_SEL_W  = SRAM_DATA_W / 8;

    // Half-word accesses per Wishbone beat, low half first
    localparam int SRAM_HALVES = WB_DATA_W / SRAM_DATA_W;
    localparam int HALF_IDX_W  = $clog2(SRAM_HALVES);

    // Word-pair address held per beat
    localparam int BEAT_ADDR_W   = SRAM_ADDR_W - HALF_IDX_W;
    // Byte address bit where the beat address starts
    localparam int BEAT_ADDR_LSB = $clog2(WB_SEL_W);

    // Cycle type identifier width
    localparam int CTI_W = 3;

    // Wishbone B4 cycle types
    typedef enum logic [CTI_W-1:0] {
        CTI_CLASSIC  = 3'b000,
        CTI_CONSTANT = 3'b001,
        CTI_INCR     = 3'b010,
        CTI_EOB      = 3'b111
    } cti_e;

    // Control FSM states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_LO   = 2'd1,
        ST_HI   = 2'd2,
        ST_ACK  = 2'd3
    } sram_state_e;

    // Active half of the beat
    // Value doubles as the SRAM address LSB
    typedef enum logic [HALF_IDX_W-1:0] {
        HALF_LO = HALF_IDX_W'(0),
        HALF_HI = HALF_IDX_W'(1)
    } sram_half_e;

endpackage

// File: rtl/sram_wb_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Three cycles per beat: low half, high half, ack
// Master must hold cyc, stb, we and cti stable until it sees ack
////////////////////////////////////////////////////////////////////////////
module sram_wb_fsm
    import sram_ctrl_pkg::*;
(
    input  logic       i_wb_clk,
    input  logic       i_rst_n,
    input  logic       i_wb_cyc,
    input  logic       i_wb_stb,
    input  logic       i_wb_we,
    input  cti_e       i_wb_cti,
    output logic       o_start,
    output logic       o_step,
    output sram_half_e o_active_half,
    output logic       o_access,
    output logic       o_wr_phase,
    output logic       o_capture_lo,
    output logic       o_load_rdata,
    output logic       o_wb_ack,
    output logic       o_sram_ce_n,
    output logic       o_sram_oe_n
);

    sram_state_e state_r;
    sram_state_e state_next;
    logic        we_r;
    logic        req;
    logic        burst_more;

    // Beat requested by the master
    assign req = i_wb_cyc && i_wb_stb;

    // Only an incrementing burst keeps going after ack
    // Constant address bursts end like classic cycles
    assign burst_more = req && (i_wb_cti == CTI_INCR);

    // Accepting edge of a new beat from idle
    assign o_start = (state_r == ST_IDLE) && req;

    // Next beat of a burst, address moves on
    assign o_step = (state_r == ST_ACK) && burst_more;

    always_comb begin
        state_next = state_r;
        case (state_r)
            ST_IDLE: begin
                if (req) begin
                    state_next = ST_LO;
                end
            end
            ST_LO: begin
                state_next = ST_HI;
            end
            ST_HI: begin
                state_next = ST_ACK;
            end
            ST_ACK: begin
                // Classic, EOB or dropped stb all return to idle
                state_next = burst_more ? ST_LO : ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r  <= ST_IDLE;
            we_r     <= 1'b0;
            o_wb_ack <= 1'b0;
        end else begin
            state_r  <= state_next;
            // Ack registered so it is high for exactly ST_ACK
            o_wb_ack <= (state_next == ST_ACK);
            // Direction latched per beat
            if (o_start || o_step) begin
                we_r <= i_wb_we;
            end
        end
    end

    // SRAM is only touched in the two half-word states
    assign o_access      = (state_r == ST_LO) || (state_r == ST_HI);
    assign o_active_half = (state_r == ST_HI) ? HALF_HI : HALF_LO;
    assign o_wr_phase    = o_access && we_r;

    // Read strobes, sampled by the gather block at the state's closing edge
    assign o_capture_lo = (state_r == ST_LO) && !we_r;
    assign o_load_rdata = (state_r == ST_HI) && !we_r;

    // Chip enable for any access, output enable for reads only
    assign o_sram_ce_n = !o_access;
    assign o_sram_oe_n = !(o_access && !we_r);

endmodule

// File: rtl/sram_addr_gen.sv
////////////////////////////////////////////////////////////////////////////
// Address must be 4-byte aligned, bits 1:0 are dropped
// Bursts are linear and wrap silently at the top of the SRAM
////////////////////////////////////////////////////////////////////////////
module sram_addr_gen
    import sram_ctrl_pkg::*;
(
    input  logic                   i_wb_clk,
    input  logic                   i_rst_n,
    input  logic [WB_ADDR_W-1:0]   i_wb_addr,
    input  logic                   i_start,
    input  logic                   i_step,
    input  sram_half_e             i_active_half,
    output logic [SRAM_ADDR_W-1:0] o_sram_addr
);

    // Word-pair address of the current beat
    logic [BEAT_ADDR_W-1:0] beat_addr_r;
    logic [BEAT_ADDR_W-1:0] beat_addr_next;

    always_comb begin
        beat_addr_next = beat_addr_r;
        if (i_start) begin
            // First beat takes the master's address
            beat_addr_next = i_wb_addr[BEAT_ADDR_LSB +: BEAT_ADDR_W];
        end else if (i_step) begin
            // Incrementing burst counts internally
            beat_addr_next = beat_addr_r + BEAT_ADDR_W'(1);
        end
    end

    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            beat_addr_r <= '0;
        end else begin
            beat_addr_r <= beat_addr_next;
        end
    end

    // Half index is the SRAM word address LSB
    assign o_sram_addr = {beat_addr_r, i_active_half};

endmodule

// File: rtl/sram_wr_slicer.sv
////////////////////////////////////////////////////////////////////////////
// Data-out and its enable are separate ports, the pad joins them
// A half with no selected byte is skipped without a write pulse
////////////////////////////////////////////////////////////////////////////
module sram_wr_slicer
    import sram_ctrl_pkg::*;
(
    input  logic [WB_DATA_W-1:0]   i_wb_data,
    input  logic [WB_SEL_W-1:0]    i_wb_sel,
    input  sram_half_e             i_active_half,
    input  logic                   i_access,
    input  logic                   i_wr_phase,
    output logic [SRAM_DATA_W-1:0] o_sram_dq,
    output logic                   o_sram_dq_oe,
    output logic                   o_sram_we_n,
    output logic                   o_sram_lb_n,
    output logic                   o_sram_ub_n
);

    logic [SRAM_DATA_W-1:0] half_data;
    logic [SRAM_SEL_W-1:0]  half_sel;

    // Little endian, low half-word goes first
    always_comb begin
        if (i_active_half == HALF_HI) begin
            half_data = i_wb_data[SRAM_DATA_W +: SRAM_DATA_W];
            half_sel  = i_wb_sel[SRAM_SEL_W +: SRAM_SEL_W];
        end else begin
            half_data = i_wb_data[0 +: SRAM_DATA_W];
            half_sel  = i_wb_sel[0 +: SRAM_SEL_W];
        end
    end

    // Byte strobes follow the selects on reads and writes alike
    assign o_sram_lb_n = !(i_access && half_sel[0]);
    assign o_sram_ub_n = !(i_access && half_sel[1]);

    // Write pulse only if this half carries a byte
    assign o_sram_we_n = !(i_wr_phase && (|half_sel));

    // Drive the bus for the whole write phase
    assign o_sram_dq_oe = i_wr_phase;
    assign o_sram_dq    = half_data;

endmodule

// File: rtl/sram_rd_gather.sv
////////////////////////////////////////////////////////////////////////////
// Read data is valid from the ack cycle until the next read beat loads
// SRAM data is sampled at the closing edge of each half-word state
////////////////////////////////////////////////////////////////////////////
module sram_rd_gather
    import sram_ctrl_pkg::*;
(
    input  logic                   i_wb_clk,
    input  logic                   i_rst_n,
    input  logic [SRAM_DATA_W-1:0] i_sram_dq,
    input  logic                   i_capture_lo,
    input  logic                   i_load_rdata,
    output logic [WB_DATA_W-1:0]   o_wb_data
);

    // Low half-word held across ST_HI
    logic [SRAM_DATA_W-1:0] lo_half_r;

    always_ff @(posedge i_wb_clk) begin
        if (i_capture_lo) begin
            lo_half_r <= i_sram_dq;
        end
    end

    // High half taken live, so no extra cycle is spent
    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_data <= '0;
        end else if (i_load_rdata) begin
            o_wb_data <= {i_sram_dq, lo_half_r};
        end
    end

endmodule

// File: rtl/sram_wb_top.sv
////////////////////////////////////////////////////////////////////////////
// Wishbone B4 slave for a 1M x 16 async SRAM, classic and linear bursts
// No stall output, each beat takes three clocks
////////////////////////////////////////////////////////////////////////////
module sram_wb_top
    import sram_ctrl_pkg::*;
(
    // Wishbone slave
    input  logic                   i_wb_clk,
    input  logic                   i_rst_n,
    input  logic                   i_wb_cyc,
    input  logic                   i_wb_stb,
    input  logic                   i_wb_we,
    input  cti_e                   i_wb_cti,
    input  logic [WB_SEL_W-1:0]    i_wb_sel,
    input  logic [WB_ADDR_W-1:0]   i_wb_addr,
    input  logic [WB_DATA_W-1:0]   i_wb_data,
    output logic [WB_DATA_W-1:0]   o_wb_data,
    output logic                   o_wb_ack,

    // SRAM pins, dq split into out, enable and in
    output logic                   o_sram_ce_n,
    output logic                   o_sram_oe_n,
    output logic                   o_sram_we_n,
    output logic                   o_sram_lb_n,
    output logic                   o_sram_ub_n,
    output logic [SRAM_ADDR_W-1:0] o_sram_addr,
    output logic [SRAM_DATA_W-1:0] o_sram_dq,
    output logic                   o_sram_dq_oe,
    input  logic [SRAM_DATA_W-1:0] i_sram_dq
);

    logic       start;
    logic       step;
    sram_half_e active_half;
    logic       access;
    logic       wr_phase;
    logic       capture_lo;
    logic       load_rdata;

    // Sequencing and bus handshake
    sram_wb_fsm u_fsm (
        .i_wb_clk      (i_wb_clk),
        .i_rst_n       (i_rst_n),
        .i_wb_cyc      (i_wb_cyc),
        .i_wb_stb      (i_wb_stb),
        .i_wb_we       (i_wb_we),
        .i_wb_cti      (i_wb_cti),
        .o_start       (start),
        .o_step        (step),
        .o_active_half (active_half),
        .o_access      (access),
        .o_wr_phase    (wr_phase),
        .o_capture_lo  (capture_lo),
        .o_load_rdata  (load_rdata),
        .o_wb_ack      (o_wb_ack),
        .o_sram_ce_n   (o_sram_ce_n),
        .o_sram_oe_n   (o_sram_oe_n)
    );

    // Beat address and burst counter
    sram_addr_gen u_addr_gen (
        .i_wb_clk      (i_wb_clk),
        .i_rst_n       (i_rst_n),
        .i_wb_addr     (i_wb_addr),
        .i_start       (start),
        .i_step        (step),
        .i_active_half (active_half),
        .o_sram_addr   (o_sram_addr)
    );

    // Write data and byte strobes
    sram_wr_slicer u_wr_slicer (
        .i_wb_data     (i_wb_data),
        .i_wb_sel      (i_wb_sel),
        .i_active_half (active_half),
        .i_access      (access),
        .i_wr_phase    (wr_phase),
        .o_sram_dq     (o_sram_dq),
        .o_sram_dq_oe  (o_sram_dq_oe),
        .o_sram_we_n   (o_sram_we_n),
        .o_sram_lb_n   (o_sram_lb_n),
        .o_sram_ub_n   (o_sram_ub_n)
    );

    // Read data assembly
    sram_rd_gather u_rd_gather (
        .i_wb_clk     (i_wb_clk),
        .i_rst_n      (i_rst_n),
        .i_sram_dq    (i_sram_dq),
        .i_capture_lo (capture_lo),
        .i_load_rdata (load_rdata),
        .o_wb_data    (o_wb_data)
    );

endmodule

// File: testbench/sram_model.sv
////////////////////////////////////////////////////////////////////////////
// Behavioral async 1M x 16 SRAM, no access timing, level-sensitive write
// Contents start unknown, unselected bytes read back as zero
////////////////////////////////////////////////////////////////////////////
module sram_model
    import sram_ctrl_pkg::*;
(
    input  logic                   i_ce_n,
    input  logic                   i_oe_n,
    input  logic                   i_we_n,
    input  logic                   i_lb_n,
    input  logic                   i_ub_n,
    input  logic [SRAM_ADDR_W-1:0] i_addr,
    input  logic [SRAM_DATA_W-1:0] i_dq,
    input  logic                   i_dq_oe,
    output logic [SRAM_DATA_W-1:0] o_dq
);

    logic [SRAM_DATA_W-1:0] mem [0:(1 << SRAM_ADDR_W) - 1];

    // Array follows the bus while we_n is low
    // Each byte lane only when its strobe is low
    always @* begin
        if (!i_ce_n && !i_we_n && i_dq_oe) begin
            if (!i_lb_n) begin
                mem[i_addr][7:0] = i_dq[7:0];
            end
            if (!i_ub_n) begin
                mem[i_addr][15:8] = i_dq[15:8];
            end
        end
    end

    // Combinational read, driven only with oe_n low and we_n high
    assign o_dq = (!i_ce_n && !i_oe_n && i_we_n) ?
                  {i_ub_n ? 8'h00 : mem[i_addr][15:8], i_lb_n ? 8'h00 : mem[i_addr][7:0]} :
                  '0;

endmodule

// File: testbench/sram_wb_properties.sv
////////////////////////////////////////////////////////////////////////////
// Bound into the control FSM, sampled on the Wishbone clock
// The we_n pin comes from the slicer and is taken from the top level
////////////////////////////////////////////////////////////////////////////
module sram_wb_properties
    import sram_ctrl_pkg::*;
(
    input logic        i_wb_clk,
    input logic        i_rst_n,
    input cti_e        i_wb_cti,
    input sram_state_e i_state,
    input logic        i_wb_ack,
    input logic        i_ce_n,
    input logic        i_oe_n,
    input logic        i_we_n
);

    // Single-cycle ack unless an incrementing burst runs on
    ack_single: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
        (i_wb_ack && (i_wb_cti != CTI_INCR)) |=> !i_wb_ack)
        else $error("ack stayed high for two cycles outside a burst");

    // Chip stays deselected while idle
    idle_ce: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
        (i_state == ST_IDLE) |-> i_ce_n)
        else $error("ce_n low while the FSM is idle");

    // Write pulse and output enable never overlap on the SRAM pins
    write_no_oe: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
        !i_we_n |-> i_oe_n)
        else $error("oe_n low while we_n is low");

    // First edge out of reset still sees ack low
    reset_ack: assert property (@(posedge i_wb_clk)
        $rose(i_rst_n) |-> !i_wb_ack)
        else $error("ack high in the cycle after reset");

endmodule

// File: testbench/tb_sram_wb.sv
////////////////////////////////////////////////////////////////////////////
// All traffic stays in a 32-beat window at a random base, preloaded first
// Bursts use full selects, the master changes data one cycle after ack
////////////////////////////////////////////////////////////////////////////
module tb_sram_wb
    import sram_ctrl_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int WIN          = 32;
    localparam int N_PARTIAL    = 6;
    localparam int N_MIXED      = 24;
    // Preload, classic pair, partial pairs, burst plus readback, read burst, mixed
    localparam int TOTAL_BEATS  = WIN + 2 + 2 * N_PARTIAL + 8 + 6 + N_MIXED;
    // Three cycles a beat, margin for reset and one idle cycle per transfer
    localparam int TIMEOUT = (TOTAL_BEATS * 3 + TOTAL_BEATS + RESET_CYCLES + 50) * CLK_PERIOD;

    logic                   i_wb_clk, i_rst_n, i_wb_cyc, i_wb_stb, i_wb_we;
    cti_e                   i_wb_cti;
    logic [WB_SEL_W-1:0]    i_wb_sel;
    logic [WB_ADDR_W-1:0]   i_wb_addr;
    logic [WB_DATA_W-1:0]   i_wb_data, o_wb_data;
    logic                   o_wb_ack, o_sram_ce_n, o_sram_oe_n, o_sram_we_n;
    logic                   o_sram_lb_n, o_sram_ub_n, o_sram_dq_oe;
    logic [SRAM_ADDR_W-1:0] o_sram_addr;
    logic [SRAM_DATA_W-1:0] o_sram_dq, i_sram_dq, sram_rd_dq;

    // Expected window contents and per-beat stimulus
    logic [WB_DATA_W-1:0]   ref_mem [0:WIN-1];
    logic [BEAT_ADDR_W-1:0] base;
    logic [WB_DATA_W-1:0]   wdata [0:7];
    logic [WB_SEL_W-1:0]    wsel [0:7];
    logic [WB_DATA_W-1:0]   exp_q [$];
    logic [WB_DATA_W-1:0]   got_q [$];
    string                  name_q [$];
    integer                 seed;

    sram_wb_top DUT (.*);

    sram_model u_sram (
        .i_ce_n  (o_sram_ce_n),
        .i_oe_n  (o_sram_oe_n),
        .i_we_n  (o_sram_we_n),
        .i_lb_n  (o_sram_lb_n),
        .i_ub_n  (o_sram_ub_n),
        .i_addr  (o_sram_addr),
        .i_dq    (o_sram_dq),
        .i_dq_oe (o_sram_dq_oe),
        .o_dq    (sram_rd_dq)
    );

    // Board pad, controller drives while writing
    assign i_sram_dq = o_sram_dq_oe ? o_sram_dq : sram_rd_dq;

    // we_n is driven by the slicer, reached from the FSM through the top level
    bind sram_wb_fsm sram_wb_properties u_props (
        .i_wb_clk   (i_wb_clk),
        .i_rst_n    (i_rst_n),
        .i_wb_cti   (i_wb_cti),
        .i_state    (state_r),
        .i_wb_ack   (o_wb_ack),
        .i_ce_n     (o_sram_ce_n),
        .i_oe_n     (o_sram_oe_n),
        .i_we_n     (DUT.o_sram_we_n)
    );

    always #(CLK_PERIOD / 2) i_wb_clk = ~i_wb_clk;

    // Byte-wise write merge, unselected bytes keep the old value
    function automatic logic [WB_DATA_W-1:0] merge_bytes(input logic [WB_DATA_W-1:0] old_word,
                                                         input logic [WB_DATA_W-1:0] new_word,
                                                         input logic [WB_SEL_W-1:0]  sel);
        logic [WB_DATA_W-1:0] merged;
        merged = old_word;
        for (int i = 0; i < WB_SEL_W; i++) begin
            if (sel[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    function automatic int pick(input int range);
        return int'($unsigned($random(seed)) % range);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic fill_beats(input int beats, input logic full_sel);
        for (int b = 0; b < beats; b++) begin
            wdata[b] = $random(seed);
            wsel[b]  = full_sel ? 4'hf : 4'($random(seed));
        end
    endtask

    // One beat is a classic cycle, more beats an incrementing burst closed by EOB
    // Entered and left on a falling edge with the FSM idle
    task automatic wb_run(input string name, input logic we, input int idx, input int beats);
        int waited;
        for (int b = 0; b < beats; b++) begin
            i_wb_cyc  = 1'b1;
            i_wb_stb  = 1'b1;
            i_wb_we   = we;
            i_wb_sel  = we ? wsel[b] : 4'hf;
            i_wb_data = wdata[b];
            i_wb_cti  = (beats == 1) ? CTI_CLASSIC : ((b == beats - 1) ? CTI_EOB : CTI_INCR);
            // Start address only, the DUT counts the burst itself
            i_wb_addr = WB_ADDR_W'({base + BEAT_ADDR_W'(idx), 2'b00});
            if (we) begin
                ref_mem[idx + b] = merge_bytes(ref_mem[idx + b], wdata[b], wsel[b]);
            end
            waited = 0;
            do begin
                @(negedge i_wb_clk);
                waited++;
            end while (!o_wb_ack && waited < 8);
            // Three cycles from the sampling edge, or from ack to ack in a burst
            check_value({name, " ack timing"}, 3, (b == 0) ? waited : waited + 1);
            if (!we) begin
                exp_q.push_back(ref_mem[idx + b]);
                got_q.push_back(o_wb_data);
                name_q.push_back(name);
            end
            if (b < beats - 1) begin
                @(negedge i_wb_clk);
            end
        end
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_cti = CTI_CLASSIC;
        @(negedge i_wb_clk);
    endtask

    // Read data against the reference, taken at each ack
    always @(negedge i_wb_clk) begin : compare_reads
        while (got_q.size() > 0) begin
            check_value(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("Timeout after %0d time units, the DUT stopped responding", TIMEOUT);
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int idx;
        seed      = 32'hc877_6bbf;
        i_wb_clk  = 1'b0;
        i_rst_n   = 1'b0;
        i_wb_cyc  = 1'b0;
        i_wb_stb  = 1'b0;
        i_wb_we   = 1'b0;
        i_wb_cti  = CTI_CLASSIC;
        i_wb_sel  = '0;
        i_wb_addr = '0;
        i_wb_data = '0;
        base      = BEAT_ADDR_W'(pick((1 << BEAT_ADDR_W) - WIN));
        repeat (RESET_CYCLES) @(posedge i_wb_clk);
        @(negedge i_wb_clk);
        i_rst_n = 1'b1;
        @(negedge i_wb_clk);

        // Idle pins, packed as ack, ce_n, oe_n, we_n, lb_n, ub_n, dq_oe
        check_value("reset pins", 32'h3e, 32'({o_wb_ack, o_sram_ce_n, o_sram_oe_n,
                                               o_sram_we_n, o_sram_lb_n, o_sram_ub_n,
                                               o_sram_dq_oe}));
        check_value("reset state", 32'(ST_IDLE), 32'(DUT.u_fsm.state_r));

        for (int i = 0; i < WIN; i++) begin
            fill_beats(1, 1'b1);
            wb_run("preload", 1'b1, i, 1);
        end

        idx = pick(WIN);
        fill_beats(1, 1'b1);
        wb_run("classic write", 1'b1, idx, 1);
        wb_run("classic read", 1'b0, idx, 1);

        for (int n = 0; n < N_PARTIAL; n++) begin
            idx = pick(WIN);
            fill_beats(1, 1'b0);
            wb_run("partial write", 1'b1, idx, 1);
            wb_run("partial read", 1'b0, idx, 1);
        end

        idx = pick(WIN - 3);
        fill_beats(4, 1'b1);
        wb_run("burst write", 1'b1, idx, 4);
        for (int b = 0; b < 4; b++) begin
            wb_run("burst readback", 1'b0, idx + b, 1);
        end

        wb_run("burst read", 1'b0, pick(WIN - 5), 6);

        // Mixed traffic, writes with random selects
        for (int n = 0; n < N_MIXED; n++) begin
            idx = pick(WIN);
            fill_beats(1, 1'b0);
            wb_run("mixed", pick(2) == 1, idx, 1);
        end

        // Compare process drains its queue
        repeat (2) @(negedge i_wb_clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: sources.f
rtl/sram_ctrl_pkg.sv
rtl/sram_wb_fsm.sv
rtl/sram_addr_gen.sv
rtl/sram_wr_slicer.sv
rtl/sram_rd_gather.sv
rtl/sram_wb_top.sv
testbench/sram_model.sv
testbench/sram_wb_properties.sv
testbench/tb_sram_wb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SRAM controller testbench with Verilator
# Run from the project root

LOG=sim.log

verilator --binary --assert --top-module tb_sram_wb -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_sram_wb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
